// File: flist.f
+incdir+.
pic_pkg.sv
pic_core.sv
pic_mem.sv
pic_host_port.sv
pic_wrapper.sv
tb_pic_wrapper.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps -f flist.f --top-module tb_pic_wrapper \
	|| exit 1
out="$(./obj_dir/Vtb_pic_wrapper)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TEST PASSED" && exit 0 || exit 1

// File: tb_pic_wrapper.sv
`timescale 1ns/10ps
`include "pic_cfg.svh"

module tb_pic_wrapper;
	import pic_pkg::*;

	localparam int BUS_TIMEOUT = 20;
	localparam int RUN_INSTR = 64; // Well past the loop exit of the count program
	localparam logic [15:0] CTL_ADR = 16'h0000;
	localparam logic [5:0] ENC_MOVLW = 6'b110000;
	localparam logic [5:0] ENC_ADDLW = 6'b111110;
	localparam logic [5:0] ENC_ANDLW = 6'b111001;
	localparam logic [5:0] ENC_MOVWF = 6'b000000; // With d set
	localparam logic [5:0] ENC_CLRF = 6'b000001; // With d set
	localparam logic [5:0] ENC_MOVF = 6'b001000;
	localparam logic [5:0] ENC_ADDWF = 6'b000111;
	localparam logic [5:0] ENC_INCF = 6'b001010;
	localparam logic [5:0] ENC_DECF = 6'b000011;
	localparam logic [5:0] ENC_DECFSZ = 6'b001011;

	logic clk;
	logic reset;
	logic host_valid;
	host_req_t host_req;
	logic host_ready;
	logic [31:0] host_rdata;
	logic [15:0] gpio_in;
	logic [15:0] gpio_out;

	// Shadow state of the model
	logic [13:0] prog_shadow [0:`PIC_PROG_DEPTH-1];
	logic [7:0] data_shadow [0:`PIC_DATA_DEPTH-1];
	logic [7:0] porta_exp;
	logic [7:0] portb_exp;
	logic [13:0] prog_words [$];
	logic [31:0] exp_q [$];
	logic [31:0] act_q [$];
	string name_q [$];
	int err_cnt = 0;
	int chk_cnt = 0;
	integer seed;

	pic_wrapper i_pic_wrapper (
		.clk(clk),
		.reset(reset),
		.host_valid_i(host_valid),
		.host_req_i(host_req),
		.host_ready_o(host_ready),
		.host_rdata_o(host_rdata),
		.gpio_i(gpio_in),
		.gpio_o(gpio_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = !clk;
	end

	function automatic logic [13:0] op_file(input logic [5:0] opc, input logic d,
			input logic [6:0] f);
		return {opc, d, f};
	endfunction

	function automatic logic [13:0] op_lit(input logic [5:0] opc, input logic [7:0] k);
		return {opc, k};
	endfunction

	function automatic logic [13:0] op_goto(input logic [9:0] target);
		return {4'b1010, target};
	endfunction

	function automatic logic [15:0] data_adr(input logic [7:0] idx);
		return {2'b01, 4'b0000, idx, 2'b00};
	endfunction

	function automatic logic [15:0] prog_adr(input logic [9:0] idx);
		return {2'b10, 2'b00, idx, 2'b00};
	endfunction

	// Port addresses read the pins instead of the array
	function automatic logic [7:0] file_value(input logic [7:0] fa);
		if (fa == `PIC_PORTA_ADR)
			return gpio_in[7:0];
		else if (fa == `PIC_PORTB_ADR)
			return gpio_in[15:8];
		else
			return data_shadow[fa];
	endfunction

	function automatic void file_write(input logic [7:0] fa, input logic [7:0] v);
		data_shadow[fa] = v;
		if (fa == `PIC_PORTA_ADR)
			porta_exp = v;
		if (fa == `PIC_PORTB_ADR)
			portb_exp = v;
	endfunction

	// Instruction level model that restarts from PC 0 with W cleared
	function automatic void ref_run(input int n_instr);
		logic [9:0] pc;
		logic [7:0] w;
		logic [13:0] ir;
		logic [7:0] fa;
		logic [7:0] fv;
		logic [7:0] res;
		logic to_w;
		logic to_file;
		pc = '0;
		w = 8'h00;
		for (int s = 0; s < n_instr; s++) begin
			ir = prog_shadow[pc];
			fa = {1'b0, ir[6:0]};
			fv = file_value(fa);
			to_w = 1'b0;
			to_file = 1'b0;
			pc = pc + 10'd1;
			casez (ir[13:8])
				6'b1100??: res = ir[7:0];
				6'b11111?: res = w + ir[7:0];
				6'b111001: res = w & ir[7:0];
				6'b000000: res = w;
				6'b001000: res = fv;
				6'b000111: res = w + fv;
				6'b001010: res = fv + 8'd1;
				6'b000011,
				6'b001011: res = fv - 8'd1;
				6'b101???: begin
					res = 8'h00;
					pc = ir[9:0];
				end
				default: res = 8'h00; // CLRF, NOP
			endcase
			casez (ir[13:8])
				6'b1100??, 6'b11111?, 6'b111001: to_w = 1'b1;
				6'b000000, 6'b000001: to_file = ir[7];
				6'b001000, 6'b000111, 6'b001010, 6'b000011, 6'b001011: begin
					to_file = ir[7];
					to_w = !ir[7];
				end
				default: ;
			endcase
			if (ir[13:8] == 6'b001011 && res == 8'h00)
				pc = pc + 10'd1; // DECFSZ skip
			if (to_w)
				w = res;
			if (to_file)
				file_write(fa, res);
		end
	endfunction

	task automatic queue_check(input string name, input logic [31:0] act,
			input logic [31:0] exp_v);
		name_q.push_back(name);
		act_q.push_back(act);
		exp_q.push_back(exp_v);
	endtask

	task automatic bus_xfer(input logic [15:0] adr, input logic we, input logic [31:0] wdat,
			output logic [31:0] rdat);
		host_req_t req;
		int cnt;
		req.adr = adr;
		req.wdat = wdat;
		req.we = we;
		rdat = '0;
		cnt = 0;
		@(posedge clk);
		host_valid <= 1'b1;
		host_req <= req;
		@(negedge clk);
		while (!host_ready && cnt < BUS_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!host_ready) begin
			$display("Timeout: host_ready_o never rose for address 0x%04h", adr);
			$display("TEST FAILED");
			$finish;
		end else begin
			rdat = host_rdata; // Valid in the ready cycle
			@(posedge clk);
			host_valid <= 1'b0;
		end
	endtask

	task automatic host_write(input logic [15:0] adr, input logic [31:0] wdat);
		logic [31:0] unused_rdat;
		bus_xfer(adr, 1'b1, wdat, unused_rdat);
	endtask

	task automatic host_read_check(input logic [15:0] adr, input logic [31:0] exp_v,
			input string name);
		logic [31:0] rdat;
		bus_xfer(adr, 1'b0, 32'h0, rdat);
		queue_check(name, rdat, exp_v);
	endtask

	task automatic load_program();
		for (int a = 0; a < prog_words.size(); a++) begin
			host_write(prog_adr(a[9:0]), {18'b0, prog_words[a]});
			prog_shadow[a[9:0]] = prog_words[a];
		end
	endtask

	// Release, let it settle in the self loop, stop again
	task automatic run_program(input int n_instr);
		host_write(CTL_ADR, 32'd0);
		repeat (2 * n_instr + 16) @(posedge clk);
		host_write(CTL_ADR, 32'd1);
		ref_run(n_instr);
	endtask

	task automatic finish_test(input string name, input int base);
		int cnt;
		cnt = 0;
		while (act_q.size() != 0 && cnt < BUS_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (act_q.size() != 0) begin
			$display("Timeout: %0d results were never compared", act_q.size());
			$display("TEST FAILED");
			$finish;
		end else begin
			$display("Test %s: %0d error(s)", name, err_cnt - base);
		end
	endtask

	// Comparing process
	initial begin
		logic [31:0] act_v;
		logic [31:0] exp_v;
		string nm;
		forever begin
			@(posedge clk);
			while (act_q.size() != 0) begin
				act_v = act_q.pop_front();
				exp_v = exp_q.pop_front();
				nm = name_q.pop_front();
				chk_cnt++;
				if (act_v !== exp_v) begin
					$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
						$time, nm, act_v, exp_v);
					err_cnt++;
				end
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		logic [7:0] rnd_adr [0:31];
		logic [9:0] rnd_padr [0:15];
		logic [7:0] first_res [0:3];
		logic [7:0] idx;
		int base;
		reset = 1'b1;
		host_valid = 1'b0;
		host_req = '0;
		gpio_in = 16'h0000;
		seed = 36;
		porta_exp = 8'h00;
		portb_exp = 8'h00;
		for (int n = 0; n < `PIC_PROG_DEPTH; n++)
			prog_shadow[n[9:0]] = '0;
		for (int n = 0; n < `PIC_DATA_DEPTH; n++)
			data_shadow[n[7:0]] = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		base = err_cnt;
		host_read_check(CTL_ADR, 32'd1, "host_rdata_o[ctl]"); // Held out of reset
		queue_check("gpio_o", {16'b0, gpio_out}, 32'd0);
		host_write(CTL_ADR, 32'd1);
		host_read_check(CTL_ADR, 32'd1, "host_rdata_o[ctl]");
		host_write(CTL_ADR, 32'd0);
		host_read_check(CTL_ADR, 32'd0, "host_rdata_o[ctl]");
		host_write(CTL_ADR, 32'd1);
		host_read_check(CTL_ADR, 32'd1, "host_rdata_o[ctl]");
		finish_test("ctl_reg", base);

		base = err_cnt;
		for (int n = 0; n < 32; n++) begin
			rnd = $random(seed);
			rnd_adr[n[4:0]] = rnd[7:0];
			rnd = $random(seed);
			host_write(data_adr(rnd_adr[n[4:0]]), rnd); // Upper bits must be dropped
			data_shadow[rnd_adr[n[4:0]]] = rnd[7:0];
		end
		for (int n = 0; n < 32; n++) begin
			idx = rnd_adr[n[4:0]];
			host_read_check(data_adr(idx), {24'b0, data_shadow[idx]},
				$sformatf("host_rdata_o[data 0x%02h]", idx));
		end
		finish_test("data_mem", base);

		base = err_cnt;
		for (int n = 0; n < 16; n++) begin
			rnd = $random(seed);
			rnd_padr[n[3:0]] = rnd[9:0];
			rnd = $random(seed);
			host_write(prog_adr(rnd_padr[n[3:0]]), rnd);
			prog_shadow[rnd_padr[n[3:0]]] = rnd[13:0];
		end
		for (int n = 0; n < 16; n++)
			host_read_check(prog_adr(rnd_padr[n[3:0]]), {18'b0, prog_shadow[rnd_padr[n[3:0]]]},
				$sformatf("host_rdata_o[prog 0x%03h]", rnd_padr[n[3:0]]));
		finish_test("prog_mem", base);

		// Sum of 7..11 in 0x20, derived bytes in 0x22 and 0x23
		base = err_cnt;
		prog_words.delete();
		prog_words.push_back(op_file(ENC_CLRF, 1'b1, 7'h20));
		prog_words.push_back(op_file(ENC_CLRF, 1'b1, 7'h23));
		prog_words.push_back(op_lit(ENC_MOVLW, 8'd5));
		prog_words.push_back(op_file(ENC_MOVWF, 1'b1, 7'h21)); // Loop count
		prog_words.push_back(op_lit(ENC_MOVLW, 8'd7));
		prog_words.push_back(op_file(ENC_ADDWF, 1'b1, 7'h20));
		prog_words.push_back(op_lit(ENC_ADDLW, 8'd1));
		prog_words.push_back(op_file(ENC_DECFSZ, 1'b1, 7'h21));
		prog_words.push_back(op_goto(10'd5));
		prog_words.push_back(op_file(ENC_MOVF, 1'b0, 7'h20));
		prog_words.push_back(op_lit(ENC_ANDLW, 8'h3F));
		prog_words.push_back(op_file(ENC_MOVWF, 1'b1, 7'h22));
		prog_words.push_back(op_file(ENC_DECF, 1'b1, 7'h22));
		prog_words.push_back(op_file(ENC_INCF, 1'b1, 7'h23));
		prog_words.push_back(op_goto(10'd14)); // Parks here
		load_program();
		run_program(RUN_INSTR);
		for (int n = 0; n < 4; n++) begin
			idx = 8'h20 + n[7:0];
			first_res[n[1:0]] = data_shadow[idx];
			host_read_check(data_adr(idx), {24'b0, data_shadow[idx]},
				$sformatf("host_rdata_o[data 0x%02h]", idx));
		end
		finish_test("program", base);

		// Dirty the cleared bytes so a restart from PC 0 must rebuild them
		base = err_cnt;
		host_write(data_adr(8'h20), 32'hFF);
		data_shadow[8'h20] = 8'hFF;
		host_write(data_adr(8'h23), 32'hFF);
		data_shadow[8'h23] = 8'hFF;
		run_program(RUN_INSTR);
		for (int n = 0; n < 4; n++) begin
			idx = 8'h20 + n[7:0];
			host_read_check(data_adr(idx), {24'b0, first_res[n[1:0]]},
				$sformatf("host_rdata_o[data 0x%02h]", idx));
		end
		finish_test("hold_restart", base);

		base = err_cnt;
		@(posedge clk);
		gpio_in <= 16'hA53C;
		prog_words.delete();
		prog_words.push_back(op_file(ENC_MOVF, 1'b0, 7'(`PIC_PORTA_ADR))); // Pins to W
		prog_words.push_back(op_file(ENC_MOVWF, 1'b1, 7'(`PIC_PORTB_ADR)));
		prog_words.push_back(op_lit(ENC_MOVLW, 8'h5A));
		prog_words.push_back(op_file(ENC_MOVWF, 1'b1, 7'(`PIC_PORTA_ADR)));
		prog_words.push_back(op_goto(10'd4));
		load_program();
		run_program(16);
		@(negedge clk);
		queue_check("gpio_o", {16'b0, gpio_out}, {16'b0, portb_exp, porta_exp});
		host_read_check(data_adr(`PIC_PORTA_ADR), {24'b0, data_shadow[`PIC_PORTA_ADR]},
			"host_rdata_o[data 0x05]");
		finish_test("gpio", base);

		$display("Totals: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: pic_wrapper.sv
`timescale 1ns/10ps
`include "pic_cfg.svh"

module pic_wrapper (
	input logic clk,
	input logic reset,
	input logic host_valid_i,
	input pic_pkg::host_req_t host_req_i,
	output logic host_ready_o,
	output logic [31:0] host_rdata_o,
	input logic [15:0] gpio_i,
	output logic [15:0] gpio_o
);

	logic hold;
	logic step;
	logic [`PIC_PROG_AW-1:0] pc;
	logic [`PIC_INSTR_W-1:0] prog_dat;
	logic [`PIC_DATA_AW-1:0] file_adr;
	logic file_we;
	logic [7:0] file_wdat;
	logic [7:0] file_dat;
	logic host_data_we;
	logic [`PIC_DATA_AW-1:0] host_data_adr;
	logic [7:0] host_data_wdat;
	logic [7:0] host_data_rdat;
	logic host_prog_we;
	logic [`PIC_PROG_AW-1:0] host_prog_adr;
	logic [`PIC_INSTR_W-1:0] host_prog_wdat;
	logic [`PIC_INSTR_W-1:0] host_prog_rdat;

	pic_host_port i_pic_host_port (
		.clk(clk),
		.reset(reset),
		.host_valid_i(host_valid_i),
		.host_req_i(host_req_i),
		.host_ready_o(host_ready_o),
		.host_rdata_o(host_rdata_o),
		.hold_o(hold),
		.host_data_we_o(host_data_we),
		.host_data_adr_o(host_data_adr),
		.host_data_wdat_o(host_data_wdat),
		.host_prog_we_o(host_prog_we),
		.host_prog_adr_o(host_prog_adr),
		.host_prog_wdat_o(host_prog_wdat),
		.host_data_rdat_i(host_data_rdat),
		.host_prog_rdat_i(host_prog_rdat)
	);

	pic_mem i_pic_mem (
		.clk(clk),
		.reset(reset),
		.hold_i(hold),
		.pc_i(pc),
		.file_adr_i(file_adr),
		.file_we_i(file_we),
		.file_wdat_i(file_wdat),
		.host_data_we_i(host_data_we),
		.host_data_adr_i(host_data_adr),
		.host_data_wdat_i(host_data_wdat),
		.host_prog_we_i(host_prog_we),
		.host_prog_adr_i(host_prog_adr),
		.host_prog_wdat_i(host_prog_wdat),
		.gpio_i(gpio_i),
		.gpio_o(gpio_o),
		.step_o(step),
		.prog_dat_o(prog_dat),
		.file_dat_o(file_dat),
		.host_data_rdat_o(host_data_rdat),
		.host_prog_rdat_o(host_prog_rdat)
	);

	pic_core i_pic_core (
		.clk(clk),
		.reset(reset),
		.hold_i(hold),
		.step_i(step),
		.prog_dat_i(prog_dat),
		.file_dat_i(file_dat),
		.pc_o(pc),
		.file_adr_o(file_adr),
		.file_we_o(file_we),
		.file_wdat_o(file_wdat)
	);

endmodule

// File: pic_host_port.sv
`timescale 1ns/10ps
`include "pic_cfg.svh"

module pic_host_port (
	input logic clk,
	input logic reset,
	input logic host_valid_i,
	input pic_pkg::host_req_t host_req_i,
	output logic host_ready_o,
	output logic [31:0] host_rdata_o,
	output logic hold_o,
	output logic host_data_we_o,
	output logic [`PIC_DATA_AW-1:0] host_data_adr_o,
	output logic [7:0] host_data_wdat_o,
	output logic host_prog_we_o,
	output logic [`PIC_PROG_AW-1:0] host_prog_adr_o,
	output logic [`PIC_INSTR_W-1:0] host_prog_wdat_o,
	input logic [7:0] host_data_rdat_i,
	input logic [`PIC_INSTR_W-1:0] host_prog_rdat_i
);
	import pic_pkg::*;

	host_sel_e sel;
	logic ready_q;
	logic hold_q;
	logic xfer;

	always_comb begin
		case (host_req_i.adr[15:14])
			2'b00: sel = SEL_CTL;
			2'b01: sel = SEL_DATA;
			default: sel = SEL_PROG;
		endcase
	end

	assign xfer = host_valid_i && ready_q;

	// Read addresses go straight out, memories answer next cycle
	assign host_data_adr_o = host_req_i.adr[9:2];
	assign host_prog_adr_o = host_req_i.adr[11:2];
	assign host_data_wdat_o = host_req_i.wdat[7:0];
	assign host_prog_wdat_o = host_req_i.wdat[`PIC_INSTR_W-1:0];
	assign host_data_we_o = xfer && host_req_i.we && sel == SEL_DATA;
	assign host_prog_we_o = xfer && host_req_i.we && sel == SEL_PROG;

	always_ff @(posedge clk) begin
		if (reset) begin
			ready_q <= 1'b0;
			hold_q <= 1'b1; // Core stays stopped until released
		end else begin
			ready_q <= host_valid_i && !ready_q; // One-cycle pulse
			if (xfer && host_req_i.we && sel == SEL_CTL)
				hold_q <= host_req_i.wdat[0];
		end
	end

	always_comb begin
		case (sel)
			SEL_CTL: host_rdata_o = {31'b0, hold_q};
			SEL_DATA: host_rdata_o = {24'b0, host_data_rdat_i};
			default: host_rdata_o = {18'b0, host_prog_rdat_i};
		endcase
	end

	assign host_ready_o = ready_q;
	assign hold_o = hold_q;

endmodule

// File: pic_mem.sv
`timescale 1ns/10ps
`include "pic_cfg.svh"

module pic_mem (
	input logic clk,
	input logic reset,
	input logic hold_i,
	input logic [`PIC_PROG_AW-1:0] pc_i,
	input logic [`PIC_DATA_AW-1:0] file_adr_i,
	input logic file_we_i,
	input logic [7:0] file_wdat_i,
	input logic host_data_we_i,
	input logic [`PIC_DATA_AW-1:0] host_data_adr_i,
	input logic [7:0] host_data_wdat_i,
	input logic host_prog_we_i,
	input logic [`PIC_PROG_AW-1:0] host_prog_adr_i,
	input logic [`PIC_INSTR_W-1:0] host_prog_wdat_i,
	input logic [15:0] gpio_i,
	output logic [15:0] gpio_o,
	output logic step_o,
	output logic [`PIC_INSTR_W-1:0] prog_dat_o,
	output logic [7:0] file_dat_o,
	output logic [7:0] host_data_rdat_o,
	output logic [`PIC_INSTR_W-1:0] host_prog_rdat_o
);

	logic [`PIC_INSTR_W-1:0] prog_mem [0:`PIC_PROG_DEPTH-1];
	logic [7:0] data_mem [0:`PIC_DATA_DEPTH-1];
	logic step_q;
	logic [7:0] porta_q;
	logic [7:0] portb_q;

	initial begin
		for (int i = 0; i < `PIC_PROG_DEPTH; i++)
			prog_mem[i] = '0;
		for (int j = 0; j < `PIC_DATA_DEPTH; j++)
			data_mem[j] = '0;
	end

	// Setup/run alternation, parked in setup while held
	always_ff @(posedge clk) begin
		if (reset || hold_i)
			step_q <= 1'b0;
		else
			step_q <= !step_q;
	end

	always_ff @(posedge clk) begin
		prog_dat_o <= prog_mem[pc_i];
		host_prog_rdat_o <= prog_mem[host_prog_adr_i];
		host_data_rdat_o <= data_mem[host_data_adr_i];
		if (!step_q) begin // Operand fetch for the decoded word
			if (file_adr_i == `PIC_PORTA_ADR)
				file_dat_o <= gpio_i[7:0];
			else if (file_adr_i == `PIC_PORTB_ADR)
				file_dat_o <= gpio_i[15:8];
			else
				file_dat_o <= data_mem[file_adr_i];
		end
	end

	always @(posedge clk) begin
		if (file_we_i)
			data_mem[file_adr_i] <= file_wdat_i;
		if (host_data_we_i)
			data_mem[host_data_adr_i] <= host_data_wdat_i; // Last one wins
		if (host_prog_we_i)
			prog_mem[host_prog_adr_i] <= host_prog_wdat_i;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			porta_q <= 8'h00;
			portb_q <= 8'h00;
		end else if (file_we_i) begin
			if (file_adr_i == `PIC_PORTA_ADR)
				porta_q <= file_wdat_i;
			if (file_adr_i == `PIC_PORTB_ADR)
				portb_q <= file_wdat_i;
		end
	end

	assign step_o = step_q;
	assign gpio_o = {portb_q, porta_q};

endmodule

// File: pic_core.sv
`timescale 1ns/10ps
`include "pic_cfg.svh"

module pic_core (
	input logic clk,
	input logic reset,
	input logic hold_i,
	input logic step_i,
	input logic [`PIC_INSTR_W-1:0] prog_dat_i,
	input logic [7:0] file_dat_i,
	output logic [`PIC_PROG_AW-1:0] pc_o,
	output logic [`PIC_DATA_AW-1:0] file_adr_o,
	output logic file_we_o,
	output logic [7:0] file_wdat_o
);
	import pic_pkg::*;

	localparam logic [`PIC_PROG_AW-1:0] PC_INC = 1;
	localparam logic [`PIC_PROG_AW-1:0] PC_SKIP = 2;

	pic_instr_t instr;
	logic [7:0] w_q;
	logic [`PIC_PROG_AW-1:0] pc_q;
	logic [`PIC_PROG_AW-1:0] pc_nxt;
	logic [7:0] res;
	logic to_w;
	logic to_file;
	logic run;

	// Standard 14-bit PIC encodings
	function automatic pic_instr_t decode(input logic [`PIC_INSTR_W-1:0] ir);
		pic_instr_t di;
		di.d = ir[7];
		di.f = ir[6:0];
		di.k = ir[10:0];
		casez (ir)
			14'b11_00??_????_????: di.op = OP_MOVLW;
			14'b11_111?_????_????: di.op = OP_ADDLW;
			14'b11_1001_????_????: di.op = OP_ANDLW;
			14'b00_0000_1???_????: di.op = OP_MOVWF;
			14'b00_0001_1???_????: di.op = OP_CLRF;
			14'b00_1000_????_????: di.op = OP_MOVF;
			14'b00_0111_????_????: di.op = OP_ADDWF;
			14'b00_1010_????_????: di.op = OP_INCF;
			14'b00_0011_????_????: di.op = OP_DECF;
			14'b00_1011_????_????: di.op = OP_DECFSZ;
			14'b10_1???_????_????: di.op = OP_GOTO;
			default: di.op = OP_NOP;
		endcase
		return di;
	endfunction

	assign instr = decode(prog_dat_i);

	// ALU result
	always_comb begin
		case (instr.op)
			OP_MOVLW: res = instr.k[7:0];
			OP_ADDLW: res = w_q + instr.k[7:0];
			OP_ANDLW: res = w_q & instr.k[7:0];
			OP_MOVWF: res = w_q;
			OP_MOVF: res = file_dat_i;
			OP_ADDWF: res = w_q + file_dat_i;
			OP_INCF: res = file_dat_i + 8'd1;
			OP_DECF,
			OP_DECFSZ: res = file_dat_i - 8'd1;
			default: res = 8'h00; // CLRF, and harmless for the rest
		endcase
	end

	// Where the result goes
	always_comb begin
		to_w = 1'b0;
		to_file = 1'b0;
		case (instr.op)
			OP_MOVLW,
			OP_ADDLW,
			OP_ANDLW: to_w = 1'b1;
			OP_MOVWF,
			OP_CLRF: to_file = 1'b1;
			OP_MOVF,
			OP_ADDWF,
			OP_INCF,
			OP_DECF,
			OP_DECFSZ: begin
				to_file = instr.d;
				to_w = !instr.d;
			end
			default: ;
		endcase
	end

	always_comb begin
		if (instr.op == OP_GOTO) begin
			pc_nxt = instr.k[`PIC_PROG_AW-1:0];
		end else if (instr.op == OP_DECFSZ && res == 8'h00) begin
			pc_nxt = pc_q + PC_SKIP; // Skip the next word
		end else begin
			pc_nxt = pc_q + PC_INC;
		end
	end

	assign run = step_i && !hold_i;

	// Next PC goes out in the run cycle so the fetch is ready for setup
	assign pc_o = run ? pc_nxt : pc_q;
	assign file_adr_o = {1'b0, instr.f};
	assign file_we_o = run && to_file;
	assign file_wdat_o = res;

	always_ff @(posedge clk) begin
		if (reset || hold_i) begin
			w_q <= 8'h00;
			pc_q <= '0;
		end else if (step_i) begin
			pc_q <= pc_nxt;
			if (to_w)
				w_q <= res;
		end
	end

endmodule

// File: pic_pkg.sv
package pic_pkg;

	// Supported subset, everything else decodes to NOP
	typedef enum logic [3:0] {
		OP_NOP,
		OP_MOVLW,
		OP_ADDLW,
		OP_ANDLW,
		OP_MOVWF,
		OP_MOVF,
		OP_ADDWF,
		OP_INCF,
		OP_DECF,
		OP_CLRF,
		OP_DECFSZ,
		OP_GOTO
	} pic_op_e;

	typedef struct packed {
		pic_op_e op;
		logic d; // 1 sends the result to the file
		logic [6:0] f;
		logic [10:0] k; // Literal in the low byte, GOTO target in full
	} pic_instr_t;

	typedef struct packed {
		logic [15:0] adr; // Byte address
		logic [31:0] wdat;
		logic we;
	} host_req_t;

	typedef enum logic [1:0] {
		SEL_CTL,
		SEL_DATA,
		SEL_PROG
	} host_sel_e;

endpackage

// File: pic_cfg.svh
`ifndef PIC_CFG_SVH
`define PIC_CFG_SVH

// Memory sizes of the 'F84 style part
`define PIC_PROG_DEPTH 1024
`define PIC_DATA_DEPTH 256

`define PIC_PROG_AW 10 // Program word index
`define PIC_DATA_AW 8 // File register index

`define PIC_INSTR_W 14

// GPIO ports in the file space
`define PIC_PORTA_ADR 8'd5
`define PIC_PORTB_ADR 8'd6

`endif
